/* tb/seq_trace.txt */
# columns: opcode, host (hex), value (hex), expected (hex)
# U load, C create, I ignored create, X load and create together, R receive, W wait for idle
# expected is the counter after the command, the receive result, or the printed value for W
R 0 00000000 00000000
R 3 00000000 00000000
C 0 00000000 00000001
W 0 00000000 00000001
R 0 00000000 00000001
U 1 00000009 00000009
C 1 00000000 0000000A
W 1 00000000 0000000A
R 1 00000000 0000000A
R 0 00000000 00000001
U 2 0001869F 0001869F
C 2 00000000 000186A0
W 2 00000000 000186A0
R 2 00000000 000186A0
U 3 3B9AC9FF 3B9AC9FF
C 3 00000000 3B9ACA00
# both creates land while the converter is busy and are dropped
C 3 00000000 3B9ACA00
C 0 00000000 00000001
W 3 00000000 3B9ACA00
R 3 00000000 3B9ACA00
R 0 00000000 00000001
I 2 00000000 000186A0
W 2 00000000 00000000
R 2 00000000 000186A0
X 4 00000055 00000055
W 4 00000000 00000000
R 4 00000000 00000055
U 5 FFFFFFFF FFFFFFFF
C 5 00000000 00000000
W 5 00000000 00000000
R 5 00000000 00000000
R 1 00000000 0000000A

/* all.f */
verilog/seq_pkg.sv
verilog/seq_conv_if.sv
verilog/seq_counter_table.sv
verilog/binary_to_bcd.sv
verilog/bcd_to_ascii.sv
verilog/sequence_generator.sv
tb/sequence_generator_assert.sv
tb/sequence_generator_tb.sv

/* Makefile */
# Verilator simulation of the sequence generator

VERILATOR ?= verilator
TOP       ?= sequence_generator_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/sequence_generator_tb.sv */
// sequence generator testbench
`timescale 1ns/1ns

module sequence_generator_tb;

	localparam int HOST_ADDR_W     = 4;
	localparam int HOSTS           = 1 << HOST_ADDR_W;
	localparam int RESET_CYCLES    = 16;
	localparam int CYCLES_PER_LINE = 40;

	logic                   clk;
	logic                   rst;
	logic                   update_i;
	logic [HOST_ADDR_W-1:0] update_addr_i;
	seq_pkg::seq_t          update_value_i;
	logic                   create_i;
	logic [HOST_ADDR_W-1:0] send_addr_i;
	logic                   ignore_i;
	logic                   receive_i;
	logic [HOST_ADDR_W-1:0] recv_addr_i;
	seq_pkg::seq_t          expected_seq_o;
	seq_pkg::ascii_t        outgoing_seq_o;
	seq_pkg::digit_cnt_t    seq_width_o;
	logic                   valid_o;
	logic                   busy_o;

	seq_pkg::seq_t model [HOSTS]; // reference counters
	logic          used [HOSTS];  // hosts named in the trace
	logic          pending;       // accepted create not yet printed
	seq_pkg::seq_t pend_val;

	logic [7:0]    t_op [$];
	int            t_addr [$];
	seq_pkg::seq_t t_val [$];
	seq_pkg::seq_t t_exp [$];
	int            t_line [$];

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int valid_seen = 0;
	int valid_exp = 0;
	int cycles = 0;
	int limit = 1000000; // replaced once the trace length is known
	logic valid_q = 1'b0;

	sequence_generator #(
		.HOST_ADDR_W (HOST_ADDR_W)
	) uut (
		.clk            (clk),
		.rst            (rst),
		.update_i       (update_i),
		.update_addr_i  (update_addr_i),
		.update_value_i (update_value_i),
		.create_i       (create_i),
		.send_addr_i    (send_addr_i),
		.ignore_i       (ignore_i),
		.receive_i      (receive_i),
		.recv_addr_i    (recv_addr_i),
		.expected_seq_o (expected_seq_o),
		.outgoing_seq_o (outgoing_seq_o),
		.seq_width_o    (seq_width_o),
		.valid_o        (valid_o),
		.busy_o         (busy_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("timeout: the run did not finish within %0d cycles", limit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// counts formatter results, flags a valid_o wider than one cycle
	always @(posedge clk) begin
		valid_q <= valid_o && !rst;
		if (!rst && valid_o) begin
			valid_seen <= valid_seen + 1;
			if (valid_q) begin
				errors = errors + 1;
				$display("valid_o stayed high for more than one cycle");
			end
		end
	end

	// decimal text, most significant digit in byte 0
	function automatic seq_pkg::ascii_t to_text(input seq_pkg::seq_t v);
		seq_pkg::ascii_t t;
		logic [3:0]      d [10];
		seq_pkg::seq_t   r;
		int              n;
		t = '0;
		r = v;
		n = 0;
		do begin
			d[n] = 4'(r % 10);
			r = r / 10;
			n++;
		end while (r != 0);
		for (int k = 0; k < n; k++) begin
			t[k*8 +: 8] = 8'h30 + {4'h0, d[n-1-k]};
		end
		return t;
	endfunction

	function automatic seq_pkg::digit_cnt_t digit_count(input seq_pkg::seq_t v);
		seq_pkg::digit_cnt_t n;
		n = 4'd1;
		while (v >= 10) begin
			v = v / 10;
			n++;
		end
		return n;
	endfunction

	task automatic check_seq(input string name, input seq_pkg::seq_t got,
			input seq_pkg::seq_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_ascii(input string name, input seq_pkg::ascii_t got,
			input seq_pkg::ascii_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_width(input string name, input seq_pkg::digit_cnt_t got,
			input seq_pkg::digit_cnt_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// trace expected column against the model
	task automatic cross_check(input int ln, input string what, input seq_pkg::seq_t m,
			input seq_pkg::seq_t t);
		if (m !== t) begin
			errors++;
			$display("trace line %0d disagrees with the model on the %s: model %h, trace %h",
				ln, what, m, t);
		end
	endtask

	task automatic receive(input int a, input seq_pkg::seq_t exp);
		@(negedge clk);
		receive_i   = 1'b1;
		recv_addr_i = a[HOST_ADDR_W-1:0];
		@(negedge clk);
		receive_i = 1'b0;
		check_seq("expected_seq_o", expected_seq_o, exp);
	endtask

	task automatic command(input int a, input seq_pkg::seq_t v, input logic upd,
			input logic cre, input logic ign);
		@(negedge clk);
		update_i       = upd;
		update_addr_i  = a[HOST_ADDR_W-1:0];
		update_value_i = v;
		create_i       = cre;
		ignore_i       = ign;
		send_addr_i    = a[HOST_ADDR_W-1:0];
		@(negedge clk);
		update_i = 1'b0;
		create_i = 1'b0;
		ignore_i = 1'b0;
	endtask

	task automatic wait_idle();
		if (pending) begin
			while (valid_o !== 1'b1) @(negedge clk);
			check_ascii("outgoing_seq_o", outgoing_seq_o, to_text(pend_val));
			check_width("seq_width_o", seq_width_o, digit_count(pend_val));
			check_flag("busy_o", busy_o, 1'b0); // busy ends with the done cycle
			pending = 1'b0;
		end else begin
			repeat (CYCLES_PER_LINE - 4) @(negedge clk); // one conversion time, no result due
		end
		while (busy_o !== 1'b0) @(negedge clk);
		@(negedge clk);
		if (valid_seen != valid_exp) begin
			errors++;
			$display("saw %0d formatter results where %0d were due", valid_seen, valid_exp);
		end
	endtask

	task automatic finish_test(input string what, input int err_before);
		tests++;
		if (errors == err_before) $display("%s: ok", what);
		else $display("%s: %0d error(s)", what, errors - err_before);
	endtask

	initial begin
		int            fd;
		int            ln;
		int            n;
		int            a;
		int            err0;
		logic [7:0]    c;
		seq_pkg::seq_t v;
		seq_pkg::seq_t e;
		string         line;
		integer        seed;
		seed = 32'h46b5_5270;
		rst = 1'b1;
		update_i = 1'b0;
		update_addr_i = '0;
		update_value_i = '0;
		create_i = 1'b0;
		send_addr_i = '0;
		ignore_i = 1'b0;
		receive_i = 1'b0;
		recv_addr_i = '0;
		pending = 1'b0;
		pend_val = '0;
		for (int h = 0; h < HOSTS; h++) used[h] = 1'b0;

		fd = $fopen("tb/seq_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file tb/seq_trace.txt");
			$display("RESULT: FAIL");
			$finish;
		end else begin
			ln = 0;
			while ($fgets(line, fd) != 0) begin
				ln++;
				if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") continue;
				n = $sscanf(line, "%c %h %h %h", c, a, v, e);
				if (n != 4) begin
					errors++;
					$display("trace line %0d is malformed", ln);
					continue;
				end
				t_op.push_back(c);
				t_addr.push_back(a % HOSTS);
				t_val.push_back(v);
				t_exp.push_back(e);
				t_line.push_back(ln);
				used[a % HOSTS] = 1'b1;
			end
			$fclose(fd);
		end
		limit = RESET_CYCLES + CYCLES_PER_LINE * (t_op.size() + 2 * HOSTS);

		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		err0 = errors;
		for (int h = 0; h < HOSTS; h++) begin
			model[h] = '0;
			receive(h, '0);
		end
		finish_test("reset readout of all hosts", err0);

		// random values in hosts the trace never touches
		for (int h = 0; h < HOSTS; h++) begin
			if (!used[h]) begin
				model[h] = $random(seed);
				command(h, model[h], 1'b1, 1'b0, 1'b0);
			end
		end

		for (int i = 0; i < t_op.size(); i++) begin
			err0 = errors;
			a = t_addr[i];
			v = t_val[i];
			e = t_exp[i];
			case (t_op[i])
				"U": begin
					command(a, v, 1'b1, 1'b0, 1'b0);
					model[a] = v;
					cross_check(t_line[i], "loaded value", model[a], e);
				end
				"C", "I": begin
					command(a, v, 1'b0, 1'b1, t_op[i] == "I");
					if (t_op[i] == "C" && !pending) begin
						model[a] = model[a] + 1; // wraps at 32 bits
						pending = 1'b1;
						pend_val = model[a];
						valid_exp++;
					end else if (t_op[i] == "C") begin
						check_flag("busy_o", busy_o, 1'b1); // dropped, converter still working
					end
					cross_check(t_line[i], "counter after create", model[a], e);
				end
				"X": begin
					command(a, v, 1'b1, 1'b1, 1'b0);
					model[a] = v; // the load wins, no conversion
					cross_check(t_line[i], "counter after load and create", model[a], e);
				end
				"R": begin
					cross_check(t_line[i], "expected number", model[a], e);
					receive(a, model[a]);
				end
				"W": begin
					if (pending) cross_check(t_line[i], "printed value", pend_val, e);
					wait_idle();
				end
				default: begin
					errors++;
					$display("trace line %0d has an unknown opcode", t_line[i]);
				end
			endcase
			finish_test($sformatf("trace line %0d (%c)", t_line[i], t_op[i]), err0);
		end

		err0 = errors;
		for (int h = 0; h < HOSTS; h++) begin
			if (!used[h]) receive(h, model[h]);
		end
		finish_test("readback of randomly filled hosts", err0);

		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* tb/sequence_generator_assert.sv */
// sequence generator assertions
`timescale 1ns/1ns

module sequence_generator_assert (
	input logic                clk,
	input logic                rst,
	input logic                start_i,
	input logic                busy_i,
	input logic                valid_i,
	input seq_pkg::digit_cnt_t width_i
);

	// formatter result lasts one cycle
	valid_pulse: assert property (@(posedge clk) disable iff (rst) valid_i |=> !valid_i)
		else $error("valid_o high on two consecutive cycles");

	no_start_busy: assert property (@(posedge clk) disable iff (rst) !(start_i && busy_i))
		else $error("conversion start while the converter is busy");

	// 1 to 10 digits
	width_range: assert property (@(posedge clk) disable iff (rst)
		valid_i |-> (width_i >= 4'd1 && width_i <= 4'd10))
		else $error("seq_width_o out of range with valid_o high");

endmodule

bind sequence_generator sequence_generator_assert u_assert (
	.clk     (clk),
	.rst     (rst),
	.start_i (conv.start),
	.busy_i  (conv.busy),
	.valid_i (valid_o),
	.width_i (seq_width_o)
);

/* verilog/sequence_generator.sv */
// sequence number generator top
`timescale 1ns/1ns

module sequence_generator #(
	parameter int HOST_ADDR_W = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   update_i,
	input  logic [HOST_ADDR_W-1:0] update_addr_i,
	input  seq_pkg::seq_t          update_value_i,
	input  logic                   create_i,
	input  logic [HOST_ADDR_W-1:0] send_addr_i,
	input  logic                   ignore_i,
	input  logic                   receive_i,
	input  logic [HOST_ADDR_W-1:0] recv_addr_i,
	output seq_pkg::seq_t          expected_seq_o,
	output seq_pkg::ascii_t        outgoing_seq_o,
	output seq_pkg::digit_cnt_t    seq_width_o,
	output logic                   valid_o,
	output logic                   busy_o
);

	seq_conv_if conv ();

	seq_counter_table #(
		.HOST_ADDR_W (HOST_ADDR_W)
	) u_table (
		.clk            (clk),
		.rst            (rst),
		.update_i       (update_i),
		.update_addr_i  (update_addr_i),
		.update_value_i (update_value_i),
		.create_i       (create_i),
		.ignore_i       (ignore_i),
		.send_addr_i    (send_addr_i),
		.receive_i      (receive_i),
		.recv_addr_i    (recv_addr_i),
		.expected_seq_o (expected_seq_o),
		.conv           (conv.tbl)
	);

	binary_to_bcd u_bcd (
		.clk  (clk),
		.rst  (rst),
		.conv (conv.conv)
	);

	bcd_to_ascii u_ascii (
		.clk     (clk),
		.rst     (rst),
		.conv    (conv.fmt),
		.ascii_o (outgoing_seq_o),
		.width_o (seq_width_o),
		.valid_o (valid_o)
	);

	assign busy_o = conv.busy; // converter occupancy

endmodule

/* verilog/bcd_to_ascii.sv */
// bcd to left-justified ascii
`timescale 1ns/1ns

module bcd_to_ascii (
	input  logic                 clk,
	input  logic                 rst,
	seq_conv_if.fmt              conv,
	output seq_pkg::ascii_t      ascii_o,
	output seq_pkg::digit_cnt_t  width_o,
	output logic                 valid_o
);

	seq_pkg::digit_cnt_t msd;     // index of top nonzero digit
	seq_pkg::ascii_t     text;
	logic [3:0]          digit;

	// zero value keeps msd at 0, giving the single digit "0"
	always_comb begin
		msd = '0;
		for (int d = 1; d < seq_pkg::BCD_DIGITS; d++) begin
			if (conv.bcd[d*4 +: 4] != 4'd0) begin
				msd = seq_pkg::digit_cnt_t'(d);
			end
		end
	end

	// byte k gets digit msd-k, bytes past the count stay zero
	always_comb begin
		text  = '0;
		digit = '0;
		for (int k = 0; k < seq_pkg::BCD_DIGITS; k++) begin
			if (k <= int'(msd)) begin
				digit = conv.bcd[(int'(msd) - k)*4 +: 4];
				text[k*8 +: 8] = seq_pkg::ASCII_ZERO + {4'd0, digit};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= conv.done;
		end
	end

	always_ff @(posedge clk) begin
		if (conv.done) begin
			ascii_o <= text;
			width_o <= msd + 1'b1;
		end
	end

endmodule

/* verilog/binary_to_bcd.sv */
// serial binary to bcd converter
`timescale 1ns/1ns

module binary_to_bcd (
	input  logic clk,
	input  logic rst,
	seq_conv_if.conv conv
);

	localparam int CNT_W = $clog2(seq_pkg::SEQ_W + 1);

	seq_pkg::seq_t     bin_sr;   // remaining binary bits, msb first
	seq_pkg::bcd_t     bcd_r;
	seq_pkg::bcd_t     bcd_adj;
	logic [CNT_W-1:0]  bit_cnt;  // shifts left to do
	logic              busy_r;
	logic              done_r;
	logic              load;
	logic              shift;

	assign load  = conv.start;
	assign shift = busy_r && (bit_cnt != '0);

	// add 3 to every digit of 5 or more before the shift
	always_comb begin
		bcd_adj = bcd_r;
		for (int d = 0; d < seq_pkg::BCD_DIGITS; d++) begin
			if (bcd_r[d*4 +: 4] >= 4'd5) begin
				bcd_adj[d*4 +: 4] = bcd_r[d*4 +: 4] + 4'd3;
			end
		end
	end

	// control
	always_ff @(posedge clk) begin
		if (rst) begin
			busy_r  <= 1'b0;
			done_r  <= 1'b0;
			bit_cnt <= '0;
		end else begin
			done_r <= 1'b0;
			if (load) begin
				busy_r  <= 1'b1;
				bit_cnt <= CNT_W'(seq_pkg::SEQ_W);
			end else if (busy_r) begin
				if (bit_cnt != '0) begin
					bit_cnt <= bit_cnt - 1'b1;
				end else if (!done_r) begin
					done_r <= 1'b1; // all bits in, result stable
				end else begin
					busy_r <= 1'b0; // drop busy after the done cycle
				end
			end
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		if (load) begin
			bin_sr <= conv.binary;
			bcd_r  <= '0;
		end else if (shift) begin
			bcd_r  <= {bcd_adj[seq_pkg::BCD_W-2:0], bin_sr[seq_pkg::SEQ_W-1]};
			bin_sr <= {bin_sr[seq_pkg::SEQ_W-2:0], 1'b0};
		end
	end

	assign conv.bcd  = bcd_r;
	assign conv.done = done_r;
	assign conv.busy = busy_r;

endmodule

/* verilog/seq_counter_table.sv */
// per-host sequence counters
`timescale 1ns/1ns

module seq_counter_table #(
	parameter int HOST_ADDR_W = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   update_i,
	input  logic [HOST_ADDR_W-1:0] update_addr_i,
	input  seq_pkg::seq_t          update_value_i,
	input  logic                   create_i,
	input  logic                   ignore_i,
	input  logic [HOST_ADDR_W-1:0] send_addr_i,
	input  logic                   receive_i,
	input  logic [HOST_ADDR_W-1:0] recv_addr_i,
	output seq_pkg::seq_t          expected_seq_o,
	seq_conv_if.tbl                conv
);

	localparam int HOSTS = 1 << HOST_ADDR_W;

	seq_pkg::seq_t mem [HOSTS];
	seq_pkg::seq_t next_val;
	seq_pkg::seq_t bin_r;
	logic          start_r;
	logic          accept;

	assign next_val = mem[send_addr_i] + seq_pkg::seq_t'(1); // wraps to zero

	// a load wins over a create in the same cycle.
	// start_r is checked too, since the converter only raises busy
	// on the edge after it sees start
	assign accept = create_i && !ignore_i && !update_i && !conv.busy && !start_r;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int h = 0; h < HOSTS; h++) begin
				mem[h] <= '0;
			end
			start_r        <= 1'b0;
			expected_seq_o <= '0;
		end else begin
			start_r <= accept; // single cycle request

			if (update_i) begin
				mem[update_addr_i] <= update_value_i;
			end else if (accept) begin
				mem[send_addr_i] <= next_val;
			end

			if (receive_i) begin
				expected_seq_o <= mem[recv_addr_i]; // value before any write this edge
			end
		end
	end

	// held until the next accepted create
	always_ff @(posedge clk) begin
		if (accept) begin
			bin_r <= next_val;
		end
	end

	assign conv.start  = start_r;
	assign conv.binary = bin_r;

endmodule

/* verilog/seq_conv_if.sv */
// conversion request channel
`timescale 1ns/1ns

interface seq_conv_if;

	logic               start;  // one cycle, only while busy is low
	seq_pkg::seq_t      binary; // stable with start
	seq_pkg::bcd_t      bcd;    // valid with done
	logic               done;   // one cycle
	logic               busy;   // cycle after start through done

	// counter table side
	modport tbl (
		output start,
		output binary,
		input  busy
	);

	// converter
	modport conv (
		input  start,
		input  binary,
		output bcd,
		output done,
		output busy
	);

	// ascii formatter
	modport fmt (
		input bcd,
		input done
	);

endinterface

/* verilog/seq_pkg.sv */
// sequence number types
package seq_pkg;

	// binary counter side
	localparam int SEQ_W = 32;

	// decimal side, 2^32-1 needs ten digits
	localparam int BCD_DIGITS = 10;
	localparam int BCD_W = 4 * BCD_DIGITS;

	// one byte per digit of text
	localparam int ASCII_W = 8 * BCD_DIGITS;

	// width of the digit count field
	localparam int DIGIT_CNT_W = 4;

	// ascii code of '0', added to each digit
	localparam logic [7:0] ASCII_ZERO = 8'h30;

	typedef logic [SEQ_W-1:0] seq_t;

	// digit 0 in bits 3:0, digit 9 in bits 39:36
	typedef logic [BCD_W-1:0] bcd_t;

	// byte 0 is the first character sent, unused bytes are zero
	typedef logic [ASCII_W-1:0] ascii_t;

	typedef logic [DIGIT_CNT_W-1:0] digit_cnt_t;

endpackage
